//--- verilog.f
+incdir+dv
source/bus_progress_pkg.sv
source/bus_cycle_if.sv
source/access_launcher.sv
source/bus_cycle_tracker.sv
source/ucode_progress.sv
source/bus_progress_ctrl.sv
dv/tb_bus_progress_ctrl.sv

//--- dv/bus_progress_ref.svh
`ifndef BUS_PROGRESS_REF_SVH
`define BUS_PROGRESS_REF_SVH

// Core held, or word store off a word boundary
function automatic logic is_misaligned(input logic running, input logic wstore,
                                       input bus_progress_pkg::addr_t a);
   return !running || (wstore && (a[1:0] != 2'b00));
endfunction

// I/O region is 01xx
function automatic logic io_launches(input logic go, input logic mis,
                                     input bus_progress_pkg::addr_t a);
   return go && (a[31:30] == 2'b01) && !mis;
endfunction

// SRAM region is 1xxx
function automatic logic sram_launches(input logic go, input logic mis,
                                       input bus_progress_pkg::addr_t a);
   return go && a[31] && !mis;
endfunction

// Full word lanes unless a named size code matches
function automatic bus_progress_pkg::sel_t lane_pattern(input bus_progress_pkg::size_t sz,
                                                        input bus_progress_pkg::addr_t a);
   bus_progress_pkg::sel_t lanes;
   lanes = 4'b1111;
   if (sz == bus_progress_pkg::SIZE_HALF && a[1:0] == 2'b00) begin
      lanes = 4'b0011;  // Low half
   end else if (sz == bus_progress_pkg::SIZE_HALF && a[1:0] == 2'b10) begin
      lanes = 4'b1100;  // High half
   end else if (sz == bus_progress_pkg::SIZE_BYTE) begin
      lanes = bus_progress_pkg::SEL_RESET;
      lanes[a[1:0]] = 1'b1;
   end
   return lanes;
endfunction

// Held state trusts the strobe instead of ack_i
function automatic logic qualified_ack(input logic held, input logic sys, input logic ack,
                                       input logic stb);
   return held ? (sys || stb) : (sys || (ack && stb));
endfunction

function automatic logic held_next_state(input logic held, input logic ack, input logic stb);
   return (ack && !stb) || (ack && held);
endfunction

function automatic logic q_enable(input logic qs, input logic qr, input logic last,
                                  input logic busy);
   return (qs || qr) && !last && !busy;
endfunction

// Bus error always lets the sequencer move on
function automatic logic ucode_advances(input logic nbe, input logic rep, input logic last,
                                        input logic nz, input logic busy);
   return !nbe || ((!rep || last || !nz) && !busy);
endfunction

function automatic logic internal_write(input logic run, input logic nz, input logic lsel,
                                        input logic we);
   return run && nz && !lsel && !we;
endfunction

task automatic check_sel(input string what, input bus_progress_pkg::sel_t got,
                         input bus_progress_pkg::sel_t exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

task automatic check_bit(input string what, input logic got, input logic exp);
   if (got !== exp) begin
      mismatch_count++;
      $display("Mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
   end
endtask

`endif

//--- dv/tb_bus_progress_ctrl.sv
`timescale 1ns/1ps

module tb_bus_progress_ctrl;

   logic clk = 1'b0;
   logic RST_I;
   logic core_running, latch_sel, launch, write_arm, write_clear, word_store;
   logic no_bus_error, ack_i, sysreg_ack, sram_ack;
   logic q_sample, q_read, shift_repeat, last_shift, shift_nonzero;
   bus_progress_pkg::addr_t addr;
   bus_progress_pkg::size_t size;
   bus_progress_pkg::sel_t  sel_o, bmask;
   logic iwe, ctrlreg_we, we_o, stb_o, sram_stb, ena_q, progress_ucode, q_ack;

   int unsigned mismatch_count = 0;
   int unsigned timeout_count  = 0;

   // Reference model state
   bus_progress_pkg::sel_t m_sel, m_bmask;
   logic m_we, m_ctrl, m_stb_io, m_stb_sram, m_held;

   `include "bus_progress_ref.svh"

   always #2 clk = ~clk;  // 4 ns period

   bus_progress_ctrl u_bus_progress_ctrl (.*);

   // Compare pre-edge outputs, then advance the model
   always @(posedge clk) begin : model_check
      logic mis, io_l, sram_l, busy, q_exp;
      mis    = is_misaligned(core_running, word_store, addr);
      io_l   = io_launches(launch, mis, addr);
      sram_l = sram_launches(launch, mis, addr);
      busy   = m_stb_io | m_stb_sram;
      q_exp  = qualified_ack(m_held, sysreg_ack, ack_i, m_stb_io);
      if (!RST_I) begin
         check_sel("sel_o", sel_o, m_sel);
         check_sel("bmask", bmask, m_bmask);
         check_bit("we_o", we_o, m_we);
         check_bit("ctrlreg_we", ctrlreg_we, m_ctrl);
         check_bit("stb_o", stb_o, m_stb_io);
         check_bit("sram_stb", sram_stb, m_stb_sram);
         check_bit("q_ack", q_ack, q_exp);
         check_bit("ena_q", ena_q, q_enable(q_sample, q_read, last_shift, busy));
         check_bit("progress_ucode", progress_ucode,
                   ucode_advances(no_bus_error, shift_repeat, last_shift, shift_nonzero,
                                  busy));
         check_bit("iwe", iwe, internal_write(core_running, shift_nonzero, latch_sel, m_we));
      end
      if (RST_I) begin
         m_sel   = bus_progress_pkg::SEL_RESET;
         m_bmask = bus_progress_pkg::MASK_RESET;
         m_held  = 1'b0;
      end else begin
         if (latch_sel) begin
            m_sel   = lane_pattern(size, addr);
            m_bmask = ~m_sel;
         end
         m_held = held_next_state(m_held, ack_i, m_stb_io);  // Uses old strobe
      end
      if (RST_I || !no_bus_error) begin
         m_stb_io   = 1'b0;
         m_stb_sram = 1'b0;
      end else begin
         m_stb_io   = io_l || (m_stb_io && !q_exp);
         m_stb_sram = sram_l || (m_stb_sram && !sram_ack);
      end
      if (RST_I || write_clear || !no_bus_error) begin
         m_we   = 1'b0;
         m_ctrl = 1'b0;
      end else if (write_arm) begin
         m_we   = (addr[31:30] != 2'b00) && !mis;
         m_ctrl = (addr[31:28] == bus_progress_pkg::REGION_CTRL) && !mis;
      end
   end

   task automatic drive_idle();
      launch        = 1'b0;
      latch_sel     = 1'b0;
      write_arm     = 1'b0;
      write_clear   = 1'b0;
      word_store    = 1'b0;
      ack_i         = 1'b0;
      sysreg_ack    = 1'b0;
      sram_ack      = 1'b0;
      q_sample      = 1'b0;
      q_read        = 1'b0;
      shift_repeat  = 1'b0;
      last_shift    = 1'b0;
      shift_nonzero = 1'b1;
      core_running  = 1'b1;
      no_bus_error  = 1'b1;
   endtask

   // Aligned word address in the region given by the top nibble
   function automatic bus_progress_pkg::addr_t word_addr(input logic [3:0] nib);
      return {nib, 26'($urandom), 2'b00};
   endfunction

   task automatic wait_strobe(input bit sram, input logic level, input int limit);
      int n;
      n = 0;
      while (((sram ? sram_stb : stb_o) !== level) && n < limit) begin
         @(negedge clk);
         n++;
      end
      if ((sram ? sram_stb : stb_o) !== level) begin
         timeout_count++;
         $display("Timeout at %0t: %s strobe did not go to %0b within %0d cycles",
                  $time, sram ? "SRAM" : "I/O", level, limit);
      end
   endtask

   // Launch, withhold the acknowledge, then end the cycle
   task automatic bus_access(input bit sram, input bus_progress_pkg::addr_t a,
                             input int hold);
      @(negedge clk);
      addr       = a;
      word_store = 1'b1;
      launch     = 1'b1;
      @(negedge clk);
      launch = 1'b0;
      wait_strobe(sram, 1'b1, 4);
      repeat (hold) @(negedge clk);
      check_bit("strobe held without ack", sram ? sram_stb : stb_o, 1'b1);
      if (sram) sram_ack = 1'b1;
      else if ($urandom_range(1, 0)) sysreg_ack = 1'b1;  // Either ack ends stb_o
      else ack_i = 1'b1;
      @(negedge clk);
      ack_i      = 1'b0;
      sysreg_ack = 1'b0;
      sram_ack   = 1'b0;
      wait_strobe(sram, 1'b0, 4);
   endtask

   // Launch that must not start a bus cycle
   task automatic dead_launch(input bus_progress_pkg::addr_t a, input logic run);
      @(negedge clk);
      addr         = a;
      word_store   = 1'b1;
      core_running = run;
      launch       = 1'b1;
      @(negedge clk);
      launch       = 1'b0;
      core_running = 1'b1;
      check_bit("stb_o after dead launch", stb_o, 1'b0);
      check_bit("sram_stb after dead launch", sram_stb, 1'b0);
   endtask

   task automatic arm_write(input bus_progress_pkg::addr_t a, input logic exp_we,
                            input logic exp_ctrl);
      @(negedge clk);
      addr       = a;
      word_store = 1'b1;
      write_arm  = 1'b1;
      @(negedge clk);
      write_arm   = 1'b0;
      check_bit("we_o after arm", we_o, exp_we);
      check_bit("ctrlreg_we after arm", ctrlreg_we, exp_ctrl);
      write_clear = 1'b1;
      @(negedge clk);
      write_clear = 1'b0;
      check_bit("we_o after clear", we_o, 1'b0);
      check_bit("ctrlreg_we after clear", ctrlreg_we, 1'b0);
   endtask

   task automatic random_traffic(input int cycles);
      for (int n = 0; n < cycles; n++) begin
         @(negedge clk);
         q_sample      = $urandom_range(1, 0);
         q_read        = $urandom_range(1, 0);
         shift_repeat  = $urandom_range(1, 0);
         last_shift    = $urandom_range(1, 0);
         shift_nonzero = $urandom_range(1, 0);
         latch_sel     = $urandom_range(1, 0);
         core_running  = ($urandom_range(7, 0) != 0);
         no_bus_error  = ($urandom_range(15, 0) != 0);
         write_arm     = $urandom_range(1, 0);
         write_clear   = ($urandom_range(3, 0) == 0);
         word_store    = $urandom_range(1, 0);
         addr          = $urandom;
         size          = $urandom_range(3, 0);
         ack_i         = ($urandom_range(3, 0) == 0);
         sysreg_ack    = ($urandom_range(7, 0) == 0);
         sram_ack      = ($urandom_range(3, 0) == 0);
         launch        = !m_stb_io && !m_stb_sram && ($urandom_range(2, 0) == 0);
      end
      @(negedge clk);
      drive_idle();
      no_bus_error = 1'b0;  // Flush any open strobe
      @(negedge clk);
      no_bus_error = 1'b1;
   endtask

   initial begin
      void'($urandom(32'h1faefd97));
      RST_I    = 1'b1;
      addr     = '0;
      size     = '0;
      drive_idle();
      repeat (3) @(negedge clk);
      RST_I = 1'b0;

      // Reset values, then random lane latches
      check_sel("sel_o after reset", sel_o, bus_progress_pkg::SEL_RESET);
      check_sel("bmask after reset", bmask, bus_progress_pkg::MASK_RESET);
      check_bit("stb_o after reset", stb_o, 1'b0);
      check_bit("sram_stb after reset", sram_stb, 1'b0);
      check_bit("we_o after reset", we_o, 1'b0);
      check_bit("ctrlreg_we after reset", ctrlreg_we, 1'b0);
      for (int n = 0; n < 40; n++) begin
         @(negedge clk);
         latch_sel = $urandom_range(1, 0);
         addr      = $urandom;
         case ($urandom_range(2, 0))
            0:       size = bus_progress_pkg::SIZE_HALF;
            1:       size = bus_progress_pkg::SIZE_BYTE;
            default: size = $urandom;
         endcase
      end
      @(negedge clk);
      latch_sel = 1'b0;

      // Strobes with slow acknowledges, then launches that must die
      for (int n = 0; n < 8; n++) begin
         bus_access(1'b0, word_addr(4'h4 | 4'($urandom_range(3, 0))), $urandom_range(5, 0));
         bus_access(1'b1, word_addr(4'h8 | 4'($urandom_range(7, 0))), $urandom_range(5, 0));
      end
      dead_launch(word_addr(4'h5) | 32'h2, 1'b1);  // Misaligned word store
      dead_launch(word_addr(4'hC), 1'b0);          // Core held
      dead_launch(word_addr(4'h1), 1'b1);          // No bus in 00xx

      // Write enables per region, then bus errors that clear strobe and enables
      arm_write(word_addr(4'h6), 1'b1, 1'b0);
      arm_write(word_addr(4'h9), 1'b1, 1'b0);
      arm_write(word_addr(bus_progress_pkg::REGION_CTRL), 1'b0, 1'b1);
      arm_write(word_addr(4'h1), 1'b0, 1'b0);
      @(negedge clk);
      addr       = word_addr(4'h4);
      word_store = 1'b1;
      launch     = 1'b1;
      write_arm  = 1'b1;
      @(negedge clk);
      launch       = 1'b0;
      write_arm    = 1'b0;
      wait_strobe(1'b0, 1'b1, 4);
      no_bus_error = 1'b0;
      @(negedge clk);
      no_bus_error = 1'b1;
      wait_strobe(1'b0, 1'b0, 4);
      check_bit("we_o after bus error", we_o, 1'b0);
      @(negedge clk);
      addr      = word_addr(bus_progress_pkg::REGION_CTRL);
      write_arm = 1'b1;
      @(negedge clk);
      write_arm    = 1'b0;
      no_bus_error = 1'b0;
      check_bit("ctrlreg_we before bus error", ctrlreg_we, 1'b1);
      @(negedge clk);
      no_bus_error = 1'b1;
      check_bit("ctrlreg_we after bus error", ctrlreg_we, 1'b0);

      // Held acknowledge with no strobe, then an I/O cycle in the held state
      @(negedge clk);
      ack_i = 1'b1;
      repeat (2) @(negedge clk);
      addr   = word_addr(4'h7);
      launch = 1'b1;
      @(negedge clk);
      launch = 1'b0;
      wait_strobe(1'b0, 1'b1, 4);
      check_bit("q_ack follows stb_o when held", q_ack, 1'b1);
      wait_strobe(1'b0, 1'b0, 4);
      check_bit("q_ack with strobe gone", q_ack, 1'b0);
      @(negedge clk);
      ack_i = 1'b0;
      @(negedge clk);
      bus_access(1'b0, word_addr(4'h4), 3);  // Back to normal qualifying

      random_traffic(300);

      $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
      if (mismatch_count == 0 && timeout_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule

//--- source/bus_progress_ctrl.sv
`timescale 1ns/1ps

module bus_progress_ctrl (
   input  logic                    clk,
   input  logic                    RST_I,
   input  logic                    core_running,
   input  bus_progress_pkg::addr_t addr,
   input  bus_progress_pkg::size_t size,
   input  logic                    latch_sel,
   input  logic                    launch,
   input  logic                    write_arm,
   input  logic                    write_clear,
   input  logic                    word_store,
   input  logic                    no_bus_error,
   input  logic                    ack_i,
   input  logic                    sysreg_ack,
   input  logic                    sram_ack,
   input  logic                    q_sample,
   input  logic                    q_read,
   input  logic                    shift_repeat,
   input  logic                    last_shift,
   input  logic                    shift_nonzero,
   output bus_progress_pkg::sel_t  sel_o,
   output bus_progress_pkg::sel_t  bmask,
   output logic                    iwe,
   output logic                    ctrlreg_we,
   output logic                    we_o,
   output logic                    stb_o,
   output logic                    sram_stb,
   output logic                    ena_q,
   output logic                    progress_ucode,
   output logic                    q_ack
);

   bus_cycle_if u_bus (
      .clk (clk)
   );

   // Address decode, byte lanes, write enables
   access_launcher u_access_launcher (
      .clk          (clk),
      .RST_I        (RST_I),
      .core_running (core_running),
      .addr         (addr),
      .size         (size),
      .latch_sel    (latch_sel),
      .launch       (launch),
      .write_arm    (write_arm),
      .write_clear  (write_clear),
      .word_store   (word_store),
      .no_bus_error (no_bus_error),
      .sel_o        (sel_o),
      .bmask        (bmask),
      .ctrlreg_we   (ctrlreg_we),
      .bus          (u_bus.launcher)
   );

   // Strobes held until acknowledged
   bus_cycle_tracker u_bus_cycle_tracker (
      .clk          (clk),
      .RST_I        (RST_I),
      .ack_i        (ack_i),
      .sysreg_ack   (sysreg_ack),
      .sram_ack     (sram_ack),
      .no_bus_error (no_bus_error),
      .bus          (u_bus.tracker)
   );

   // Sequencer stall and enables
   ucode_progress u_ucode_progress (
      .core_running   (core_running),
      .latch_sel      (latch_sel),
      .q_sample       (q_sample),
      .q_read         (q_read),
      .shift_repeat   (shift_repeat),
      .last_shift     (last_shift),
      .shift_nonzero  (shift_nonzero),
      .no_bus_error   (no_bus_error),
      .ena_q          (ena_q),
      .progress_ucode (progress_ucode),
      .iwe            (iwe),
      .bus            (u_bus.progress)
   );

   assign we_o     = u_bus.we;
   assign stb_o    = u_bus.stb_io;    // Wishbone strobe to I/O
   assign sram_stb = u_bus.stb_sram;
   assign q_ack    = u_bus.q_ack;

endmodule

//--- source/ucode_progress.sv
`timescale 1ns/1ps

module ucode_progress (
   input  logic          core_running,   // Qualifies internal writes
   input  logic          latch_sel,      // Byte select setup cycle
   input  logic          q_sample,       // Q takes ALU result
   input  logic          q_read,         // Q takes read data
   input  logic          shift_repeat,   // Loop the shift until done
   input  logic          last_shift,
   input  logic          shift_nonzero,  // Low for a shift by 0
   input  logic          no_bus_error,
   output logic          ena_q,
   output logic          progress_ucode,
   output logic          iwe,
   bus_cycle_if.progress bus
);

   logic bus_busy;
   logic shift_done;

   assign bus_busy = bus.stb_io | bus.stb_sram;  // Cycle outstanding on either bus

   // Shift loop may stop: not repeating, last step, or nothing to shift
   assign shift_done = ~shift_repeat | last_shift | ~shift_nonzero;

   // Q waits for the acknowledge when reading
   assign ena_q = (q_sample | q_read) & ~last_shift & ~bus_busy;

   // Bus error must never freeze the sequencer
   assign progress_ucode = (shift_done & ~bus_busy) | ~no_bus_error;

   // Internal memory is written most cycles, except
   //   selector setup, a bus write, or a shift by 0
   assign iwe = core_running & shift_nonzero & ~latch_sel & ~bus.we;

   // An open strobe stalls the microcode unless a bus error forces it on
   a_stall_on_strobe: assert property (
      @(posedge bus.clk)
      (bus_busy && no_bus_error) |-> !progress_ucode
   ) else $error("microcode advanced with a strobe outstanding");

endmodule

//--- source/bus_cycle_tracker.sv
`timescale 1ns/1ps

module bus_cycle_tracker (
   input  logic        clk,
   input  logic        RST_I,
   input  logic        ack_i,         // Acknowledge from I/O slave
   input  logic        sysreg_ack,    // Acknowledge from system registers
   input  logic        sram_ack,      // Acknowledge from SRAM
   input  logic        no_bus_error,
   bus_cycle_if.tracker bus
);

   logic stb_io_q;
   logic stb_sram_q;
   logic stb_io_nxt;
   logic stb_sram_nxt;
   logic clr_stb;
   logic ack_held;   // Slave seen holding its acknowledge
   logic held_nxt;
   logic q_ack_c;

   // Acknowledge qualifier.
   // A slave on a point to point link may keep its acknowledge asserted.
   // When that is seen with no strobe out, the acknowledge can't be trusted,
   // so the strobe itself stands in for it until the slave lets go.
   //
   //   state   sysreg ack stb  next   q_ack
   //   normal    0     1   0   held     0
   //   normal    0     1   1   normal   1
   //   held      0     0   1   normal   1
   //   held      0     1   1   held     1
   //   sysreg_ack always gives q_ack
   always_comb begin
      if (ack_held) begin
         q_ack_c = sysreg_ack | stb_io_q;  // Strobe lasts one cycle
      end else begin
         q_ack_c = sysreg_ack | (ack_i & stb_io_q);
      end
   end

   assign held_nxt = ack_i & (~stb_io_q | ack_held);  // Leave only when ack_i drops

   always_ff @(posedge clk) begin
      if (RST_I) begin
         ack_held <= 1'b0;
      end else begin
         ack_held <= held_nxt;
      end
   end

   // Strobes: set by a launch, kept until acknowledged.
   // A launch in the ack cycle keeps the strobe up.
   assign stb_io_nxt   = bus.launch_io   | (stb_io_q   & ~q_ack_c);
   assign stb_sram_nxt = bus.launch_sram | (stb_sram_q & ~sram_ack);

   assign clr_stb = RST_I | ~no_bus_error;  // Bus error aborts the cycle

   always_ff @(posedge clk) begin
      if (clr_stb) begin
         stb_io_q   <= 1'b0;
         stb_sram_q <= 1'b0;
      end else begin
         stb_io_q   <= stb_io_nxt;
         stb_sram_q <= stb_sram_nxt;
      end
   end

   assign bus.stb_io   = stb_io_q;
   assign bus.stb_sram = stb_sram_q;
   assign bus.q_ack    = q_ack_c;

   // Only one bus cycle in flight at a time
   a_one_strobe: assert property (
      @(posedge clk) disable iff (RST_I)
      !(stb_io_q && stb_sram_q)
   ) else $error("I/O and SRAM strobes high together");

   // Strobes come only from the launcher
   a_io_rise: assert property (
      @(posedge clk) disable iff (RST_I)
      $rose(stb_io_q) |-> $past(bus.launch_io)
   ) else $error("stb_io rose without launch_io");

   a_sram_rise: assert property (
      @(posedge clk) disable iff (RST_I)
      $rose(stb_sram_q) |-> $past(bus.launch_sram)
   ) else $error("stb_sram rose without launch_sram");

endmodule

//--- source/access_launcher.sv
`timescale 1ns/1ps

module access_launcher (
   input  logic                    clk,
   input  logic                    RST_I,
   input  logic                    core_running,  // Low while core is held
   input  bus_progress_pkg::addr_t addr,          // Effective address
   input  bus_progress_pkg::size_t size,          // Access size from microcode
   input  logic                    latch_sel,     // Latch byte selects
   input  logic                    launch,        // Possibly start a bus cycle
   input  logic                    write_arm,     // Possibly set write enables
   input  logic                    write_clear,   // Drop write enables
   input  logic                    word_store,    // SW must be word aligned
   input  logic                    no_bus_error,
   output bus_progress_pkg::sel_t  sel_o,
   output bus_progress_pkg::sel_t  bmask,         // Active low copy of sel_o
   output logic                    ctrlreg_we,
   bus_cycle_if.launcher           bus
);

   logic                   misaligned;
   logic                   region_ctrl;
   logic                   clr_we;
   bus_progress_pkg::sel_t sel_nxt;
   bus_progress_pkg::sel_t sel_q;
   bus_progress_pkg::sel_t bmask_q;
   logic                   we_q;
   logic                   ctrlreg_we_q;

   // A word store to an unaligned address gets no strobe and no write enable.
   // Halfwords are checked earlier in the microcode, so no such case here.
   assign misaligned = ~core_running | (word_store & (addr[1] | addr[0]));

   assign region_ctrl =
      (addr[bus_progress_pkg::ADDR_W-1 -: 4] == bus_progress_pkg::REGION_CTRL);

   // I/O is 01xx, SRAM is 1xxx
   assign bus.launch_io   = launch & ~addr[31] & addr[30] & ~misaligned;
   assign bus.launch_sram = launch &  addr[31]            & ~misaligned;

   // Lane decode from size and low address bits
   always_comb begin
      sel_nxt = 4'b1111;  // Word access by default
      case (size)
         bus_progress_pkg::SIZE_HALF: begin
            case (addr[1:0])
               2'b00:   sel_nxt = 4'b0011;
               2'b10:   sel_nxt = 4'b1100;
               default: sel_nxt = 4'b1111;  // Odd halfword, treated as word
            endcase
         end
         bus_progress_pkg::SIZE_BYTE: begin
            sel_nxt = 4'b0001 << addr[1:0];  // One hot lane
         end
         default: sel_nxt = 4'b1111;
      endcase
   end

   // Byte selects and mask move together
   always_ff @(posedge clk) begin
      if (RST_I) begin
         sel_q   <= bus_progress_pkg::SEL_RESET;
         bmask_q <= bus_progress_pkg::MASK_RESET;
      end else if (latch_sel) begin
         sel_q   <= sel_nxt;
         bmask_q <= ~sel_nxt;  // Internal memory wants active low
      end
   end

   assign clr_we = write_clear | RST_I | ~no_bus_error;  // Clear beats load

   always_ff @(posedge clk) begin
      if (clr_we) begin
         we_q         <= 1'b0;
         ctrlreg_we_q <= 1'b0;
      end else if (write_arm & no_bus_error) begin
         we_q         <= (addr[31] | addr[30]) & ~misaligned;  // SRAM or I/O
         ctrlreg_we_q <= region_ctrl & ~misaligned;
      end
   end

   assign sel_o      = sel_q;
   assign bmask      = bmask_q;
   assign bus.we     = we_q;
   assign ctrlreg_we = ctrlreg_we_q;

   // Mask register must never drift from the select register
   a_bmask_inverse: assert property (
      @(posedge clk) disable iff (RST_I)
      bmask == ~sel_o
   ) else $error("bmask is not the complement of sel_o");

endmodule

//--- source/bus_cycle_if.sv
`timescale 1ns/1ps

interface bus_cycle_if (
   input logic clk
);

   logic launch_io;    // One cycle pulse, start an I/O cycle
   logic launch_sram;  // One cycle pulse, start an SRAM cycle
   logic we;           // Bus write enable, registered
   logic stb_io;       // I/O strobe, held until acknowledged
   logic stb_sram;     // SRAM strobe, held until acknowledged
   logic q_ack;        // Qualified I/O or sysreg acknowledge

   // Address decode side, produces the launch pulses
   modport launcher (output launch_io, output launch_sram, output we);

   // Holds the strobes and filters the acknowledge
   modport tracker (input launch_io, input launch_sram,
                    output stb_io, output stb_sram, output q_ack);

   // Microcode side only looks at bus state
   modport progress (input clk, input stb_io, input stb_sram, input we, input q_ack);

endinterface

//--- source/bus_progress_pkg.sv
package bus_progress_pkg;

   // Bus geometry
   localparam int ADDR_W = 32;  // Byte address width
   localparam int LANES  = 4;   // Byte lanes per word

   // Address seen by the launcher, only the top nibble and low two bits matter
   typedef logic [ADDR_W-1:0] addr_t;

   // One bit per byte lane, bit 0 is the lowest address
   typedef logic [LANES-1:0] sel_t;

   // Access size field from the microcode word
   typedef logic [3:0] size_t;

   // Named size codes, anything else is a full word
   localparam size_t SIZE_HALF = 4'b0001;  // Halfword store
   localparam size_t SIZE_BYTE = 4'b0010;  // Byte store

   // Top address nibble of the control register space (0x2xxx_xxxx)
   localparam logic [3:0] REGION_CTRL = 4'b0010;

   // Lane state out of reset
   localparam sel_t SEL_RESET  = 4'b0000;  // No lanes selected
   localparam sel_t MASK_RESET = 4'b1111;  // Active low, all lanes masked

   // Region map in short
   //   1xxx  SRAM
   //   01xx  I/O devices
   //   0010  control registers, written through the internal memory
   //   others have no bus strobe

endpackage
